// File: logic/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

  // Scaled-down raster timing, in pixels and lines
  localparam int h_active       = 48;
  localparam int h_total        = 64;
  localparam int h_sync_start   = 52;
  localparam int h_sync_width   = 4;
  localparam int v_active       = 88;
  localparam int v_total        = 96;
  localparam int v_sync_start   = 90;
  localparam int v_sync_width   = 2;

  // Well geometry
  localparam int cell_px        = 4;
  localparam int board_cols     = 10;
  localparam int board_rows     = 20;
  localparam int board_x0       = 4;
  localparam int board_y0       = 8;
  // First pixel line of the score lamps
  localparam int score_y0       = 2;

  // hz100 cycles per gravity step
  localparam int tick_cycles    = 2048;

  // Bit order is red, green, blue
  typedef enum logic [2:0] {
    color_black   = 3'b000,
    color_blue    = 3'b001,
    color_green   = 3'b010,
    color_cyan    = 3'b011,
    color_red     = 3'b100,
    color_magenta = 3'b101,
    color_yellow  = 3'b110,
    color_white   = 3'b111
  } color_t;

  // Spawn order follows declaration order
  typedef enum logic [2:0] {
    kind_o, kind_i, kind_t, kind_l, kind_j, kind_s, kind_z
  } piece_kind_t;

  typedef enum logic [2:0] {
    st_idle, st_spawn, st_fall, st_lock, st_clear, st_over
  } game_state_t;

  typedef struct packed {
    logic [6:0] x;
    logic [6:0] y;
    logic       active;
    logic       hsync;
    logic       vsync;
  } scan_t;

  // col and row locate the top left of the 4x4 shape box
  typedef struct packed {
    piece_kind_t       kind;
    logic [1:0]        rot;
    logic signed [4:0] col;
    logic signed [5:0] row;
  } piece_t;

  typedef color_t [board_cols-1:0] well_row_t;
  typedef well_row_t [board_rows-1:0] well_t;

  localparam well_row_t row_empty  = '{default: color_black};
  localparam well_t     well_empty = '{default: row_empty};

  function automatic color_t piece_color(piece_kind_t kind);
    case (kind)
      kind_o:  return color_yellow;
      kind_i:  return color_cyan;
      kind_t:  return color_magenta;
      kind_l:  return color_white;
      kind_j:  return color_blue;
      kind_s:  return color_green;
      kind_z:  return color_red;
      default: return color_black;
    endcase
  endfunction

  // Four cells per shape, one nibble each as {row[1:0], col[1:0]}
  function automatic logic [15:0] shape_cells(piece_kind_t kind, logic [1:0] rot);
    logic [15:0] cells;
    case (kind)
      kind_i: cells = rot[0] ? 16'h159d : 16'h0123;
      kind_t: begin
        case (rot)
          2'd0:    cells = 16'h0125;
          2'd1:    cells = 16'h1459;
          2'd2:    cells = 16'h1456;
          default: cells = 16'h0458;
        endcase
      end
      kind_l: begin
        case (rot)
          2'd0:    cells = 16'h0124;
          2'd1:    cells = 16'h0159;
          2'd2:    cells = 16'h2456;
          default: cells = 16'h0489;
        endcase
      end
      kind_j: begin
        case (rot)
          2'd0:    cells = 16'h0126;
          2'd1:    cells = 16'h1589;
          2'd2:    cells = 16'h0456;
          default: cells = 16'h0148;
        endcase
      end
      kind_s:  cells = rot[0] ? 16'h0459 : 16'h1245;
      kind_z:  cells = rot[0] ? 16'h1458 : 16'h0156;
      // O piece, same in every rotation
      default: cells = 16'h0145;
    endcase
    return cells;
  endfunction

endpackage

`default_nettype wire

// File: logic/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing import tetris_pkg::*; (
  input  logic  hz100,
  input  logic  rst_n,
  output scan_t scan
);

  logic [6:0] h_count;
  logic [6:0] v_count;
  logic       h_last;
  logic       v_last;
  logic       h_in_sync;
  logic       v_in_sync;

  // End of line and end of frame
  assign h_last = (h_count == 7'(h_total - 1));
  assign v_last = (v_count == 7'(v_total - 1));

  always_ff @(posedge hz100 or negedge rst_n) begin
    if (!rst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      if (h_last) begin
        h_count <= '0;
        // Line count steps on horizontal wrap
        if (v_last) begin
          v_count <= '0;
        end else begin
          v_count <= v_count + 7'd1;
        end
      end else begin
        h_count <= h_count + 7'd1;
      end
    end
  end

  // Sync pulse windows
  assign h_in_sync = (h_count >= 7'(h_sync_start)) &&
                     (h_count < 7'(h_sync_start + h_sync_width));
  assign v_in_sync = (v_count >= 7'(v_sync_start)) &&
                     (v_count < 7'(v_sync_start + v_sync_width));

  always_comb begin
    scan.x      = h_count;
    scan.y      = v_count;
    scan.active = (h_count < 7'(h_active)) && (v_count < 7'(v_active));
    // Syncs are active low
    scan.hsync  = !h_in_sync;
    scan.vsync  = !v_in_sync;
  end

  // Counters stay inside the frame
  a_counters_in_range: assert property (
    @(posedge hz100) disable iff (!rst_n)
    (h_count < 7'(h_total)) && (v_count < 7'(v_total))
  );

endmodule

`default_nettype wire

// File: logic/tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider import tetris_pkg::*; (
  input  logic hz100,
  input  logic rst_n,
  output logic gravity_tick
);

  logic [$clog2(tick_cycles)-1:0] count;

  // Free-running count, single-cycle enable on wrap
  always_ff @(posedge hz100 or negedge rst_n) begin
    if (!rst_n) begin
      count        <= '0;
      gravity_tick <= 1'b0;
    end else if (count == ($bits(count))'(tick_cycles - 1)) begin
      count        <= '0;
      gravity_tick <= 1'b1;
    end else begin
      count        <= count + 1'b1;
      gravity_tick <= 1'b0;
    end
  end

  // Pulse never stretches past one cycle
  a_tick_one_cycle: assert property (
    @(posedge hz100) disable iff (!rst_n) gravity_tick |=> !gravity_tick
  );

endmodule

`default_nettype wire

// File: logic/tetris_game.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_game import tetris_pkg::*; (
  input  logic        hz100,
  input  logic        rst_n,
  input  logic        gravity_tick,
  input  logic        move_left,
  input  logic        move_right,
  input  logic        rotate,
  input  logic        drop,
  input  logic        start,
  output well_t       well,
  output piece_t      piece,
  output logic        piece_live,
  output logic [7:0]  score,
  output logic        game_over
);

  typedef struct packed {
    logic start;
    logic drop;
    logic rotate;
    logic right;
    logic left;
  } buttons_t;

  buttons_t    btn_raw;
  buttons_t    btn_meta;
  buttons_t    btn_sync;
  buttons_t    btn_prev;
  buttons_t    btn_edge;

  game_state_t state;
  well_t       well_q;
  piece_t      piece_q;
  piece_t      cand;
  piece_kind_t kind_next;
  logic [7:0]  score_q;
  logic [4:0]  clear_row;
  logic [15:0] lock_cells;
  logic        move_req;
  logic        move_down;
  logic        cand_ok;

  // Every cell of p lies inside the well
  function automatic logic in_bounds(piece_t p);
    logic [15:0] cells;
    int          r;
    int          c;
    logic        ok;
    cells = shape_cells(p.kind, p.rot);
    ok = 1'b1;
    for (int k = 0; k < 4; k++) begin
      r = int'(p.row) + int'(cells[4*k+3 -: 2]);
      c = int'(p.col) + int'(cells[4*k+1 -: 2]);
      if (r < 0 || r >= board_rows || c < 0 || c >= board_cols) ok = 1'b0;
    end
    return ok;
  endfunction

  // Inside the well and every target cell empty
  function automatic logic fits(piece_t p, well_t w);
    logic [15:0] cells;
    int          r;
    int          c;
    logic        ok;
    cells = shape_cells(p.kind, p.rot);
    ok = in_bounds(p);
    for (int k = 0; k < 4; k++) begin
      r = int'(p.row) + int'(cells[4*k+3 -: 2]);
      c = int'(p.col) + int'(cells[4*k+1 -: 2]);
      if (ok && w[r][c] != color_black) ok = 1'b0;
    end
    return ok;
  endfunction

  function automatic logic row_full(well_row_t row);
    logic full;
    full = 1'b1;
    for (int c = 0; c < board_cols; c++) begin
      if (row[c] == color_black) full = 1'b0;
    end
    return full;
  endfunction

  // Fixed repeating spawn order
  function automatic piece_kind_t next_kind(piece_kind_t k);
    return (k == kind_z) ? kind_o : piece_kind_t'(k + 3'd1);
  endfunction

  assign btn_raw = '{start: start, drop: drop, rotate: rotate,
                     right: move_right, left: move_left};

  // Two-flop synchronizer plus one flop for edge detect
  always_ff @(posedge hz100 or negedge rst_n) begin
    if (!rst_n) begin
      btn_meta <= '0;
      btn_sync <= '0;
      btn_prev <= '0;
    end else begin
      btn_meta <= btn_raw;
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
    end
  end

  assign btn_edge = btn_sync & ~btn_prev;

  // One candidate position per cycle, down beats side moves
  always_comb begin
    cand      = piece_q;
    move_req  = 1'b0;
    move_down = 1'b0;
    if (state == st_spawn) begin
      // New piece at column 3, row 0, rotation 0
      cand.kind = kind_next;
      cand.rot  = 2'd0;
      cand.col  = 5'sd3;
      cand.row  = 6'sd0;
    end else if (gravity_tick || btn_edge.drop) begin
      cand.row  = piece_q.row + 6'sd1;
      move_req  = 1'b1;
      move_down = 1'b1;
    end else if (btn_edge.left) begin
      cand.col  = piece_q.col - 5'sd1;
      move_req  = 1'b1;
    end else if (btn_edge.right) begin
      cand.col  = piece_q.col + 5'sd1;
      move_req  = 1'b1;
    end else if (btn_edge.rotate) begin
      cand.rot  = piece_q.rot + 2'd1;
      move_req  = 1'b1;
    end
  end

  assign cand_ok    = fits(cand, well_q);
  assign lock_cells = shape_cells(piece_q.kind, piece_q.rot);

  // Piece position, only valid while piece_live
  always_ff @(posedge hz100) begin
    if (cand_ok && (state == st_spawn || (state == st_fall && move_req))) begin
      piece_q <= cand;
    end
  end

  always_ff @(posedge hz100 or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      well_q     <= well_empty;
      score_q    <= '0;
      kind_next  <= kind_o;
      piece_live <= 1'b0;
      clear_row  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (btn_edge.start) begin
            well_q    <= well_empty;
            score_q   <= '0;
            kind_next <= kind_o;
            state     <= st_spawn;
          end
        end
        st_spawn: begin
          kind_next <= next_kind(kind_next);
          if (cand_ok) begin
            piece_live <= 1'b1;
            state      <= st_fall;
          end else begin
            state      <= st_over;
          end
        end
        st_fall: begin
          // Blocked downward step locks the piece
          if (move_req && move_down && !cand_ok) state <= st_lock;
        end
        st_lock: begin
          for (int k = 0; k < 4; k++) begin
            well_q[int'(piece_q.row) + int'(lock_cells[4*k+3 -: 2])]
                  [int'(piece_q.col) + int'(lock_cells[4*k+1 -: 2])]
                  <= piece_color(piece_q.kind);
          end
          piece_live <= 1'b0;
          clear_row  <= 5'(board_rows - 1);
          state      <= st_clear;
        end
        st_clear: begin
          if (row_full(well_q[clear_row])) begin
            // Rows above drop by one, same row checked again
            for (int i = board_rows - 1; i > 0; i--) begin
              if (i <= int'(clear_row)) well_q[i] <= well_q[i-1];
            end
            well_q[0] <= row_empty;
            if (score_q != 8'hff) score_q <= score_q + 8'd1;
          end else if (clear_row == 5'd0) begin
            state     <= st_spawn;
          end else begin
            clear_row <= clear_row - 5'd1;
          end
        end
        st_over: begin
          if (btn_edge.start) begin
            well_q  <= well_empty;
            score_q <= '0;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign well      = well_q;
  assign piece     = piece_q;
  assign score     = score_q;
  assign game_over = (state == st_over);

  // Live piece always sits inside the well
  a_piece_in_well: assert property (
    @(posedge hz100) disable iff (!rst_n) piece_live |-> in_bounds(piece_q)
  );

  // Score only drops through a restart
  a_score_monotonic: assert property (
    @(posedge hz100) disable iff (!rst_n) !btn_edge.start |=> score_q >= $past(score_q)
  );

endmodule

`default_nettype wire

// File: logic/board_render.sv
`timescale 1ns/1ps
`default_nettype none

module board_render import tetris_pkg::*; (
  input  scan_t  scan,
  input  well_t  well,
  input  piece_t piece,
  input  logic   piece_live,
  input  logic   game_over,
  output color_t board_color
);

  logic [15:0] cells;

  assign cells = shape_cells(piece.kind, piece.rot);

  always_comb begin
    int     wx;
    int     wy;
    int     cc;
    int     rr;
    int     rel_c;
    int     rel_r;
    logic   in_well;
    logic   in_frame;
    logic   hit;
    color_t stored;
    // Pixel offset from the well origin
    wx       = int'(scan.x) - board_x0;
    wy       = int'(scan.y) - board_y0;
    in_well  = (wx >= 0) && (wx < board_cols * cell_px) &&
               (wy >= 0) && (wy < board_rows * cell_px);
    // Well plus a one-cell border
    in_frame = (wx >= -cell_px) && (wx < (board_cols + 1) * cell_px) &&
               (wy >= -cell_px) && (wy < (board_rows + 1) * cell_px);
    cc       = wx / cell_px;
    rr       = wy / cell_px;
    // Cell relative to the piece box
    rel_c    = cc - int'(piece.col);
    rel_r    = rr - int'(piece.row);
    hit      = 1'b0;
    if (piece_live && rel_c >= 0 && rel_c < 4 && rel_r >= 0 && rel_r < 4) begin
      for (int k = 0; k < 4; k++) begin
        if (cells[4*k+3 -: 4] == 4'(rel_r * 4 + rel_c)) hit = 1'b1;
      end
    end
    stored = color_black;
    if (in_well) stored = well[rr][cc];
    // Game over paints the stack red
    if (game_over && stored != color_black) stored = color_red;

    if (!scan.active) begin
      board_color = color_black;
    end else if (in_well) begin
      board_color = hit ? piece_color(piece.kind) : stored;
    end else if (in_frame) begin
      board_color = color_white;
    end else begin
      board_color = color_black;
    end
  end

endmodule

`default_nettype wire

// File: logic/score_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module score_overlay import tetris_pkg::*; (
  input  logic       hz100,
  input  logic       rst_n,
  input  scan_t      scan,
  input  color_t     board_color,
  input  logic [7:0] score,
  output logic       red,
  output logic       green,
  output logic       blue,
  output logic       hsync,
  output logic       vsync
);

  int         lamp_x;
  int         lamp_y;
  logic       lamp_on;
  logic [2:0] lamp_idx;
  color_t     pix;

  // Lamp strip on score_y0, MSB at board_x0
  always_comb begin
    lamp_x   = int'(scan.x) - board_x0;
    lamp_y   = int'(scan.y) - score_y0;
    lamp_on  = scan.active &&
               (lamp_x >= 0) && (lamp_x < $bits(score) * cell_px) &&
               (lamp_y >= 0) && (lamp_y < cell_px);
    lamp_idx = 3'($bits(score) - 1 - lamp_x / cell_px);
  end

  // Lamp wins over the board
  always_comb begin
    if (lamp_on) begin
      pix = score[lamp_idx] ? color_yellow : color_blue;
    end else begin
      pix = board_color;
    end
  end

  // One register stage keeps pixels and syncs aligned
  always_ff @(posedge hz100 or negedge rst_n) begin
    if (!rst_n) begin
      {red, green, blue} <= 3'b000;
      hsync              <= 1'b1;
      vsync              <= 1'b1;
    end else begin
      {red, green, blue} <= 3'(pix);
      hsync              <= scan.hsync;
      vsync              <= scan.vsync;
    end
  end

endmodule

`default_nettype wire

// File: logic/tetris_top.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_top import tetris_pkg::*; (
  input  logic       hz100,
  input  logic       rst_n,
  input  logic       move_left,
  input  logic       move_right,
  input  logic       rotate,
  input  logic       drop,
  input  logic       start,
  output logic       red,
  output logic       green,
  output logic       blue,
  output logic       hsync,
  output logic       vsync,
  output logic       game_over,
  output logic [7:0] score
);

  logic   gravity_tick;
  scan_t  scan;
  well_t  well;
  piece_t piece;
  logic   piece_live;
  color_t board_color;

  // Gravity enable
  tick_divider tick0 (.hz100(hz100), .rst_n(rst_n), .gravity_tick(gravity_tick));

  // Raster scan
  vga_timing timing0 (.hz100(hz100), .rst_n(rst_n), .scan(scan));

  tetris_game game0 (
    .hz100(hz100), .rst_n(rst_n), .gravity_tick(gravity_tick),
    .move_left(move_left), .move_right(move_right), .rotate(rotate),
    .drop(drop), .start(start),
    .well(well), .piece(piece), .piece_live(piece_live),
    .score(score), .game_over(game_over)
  );

  board_render render0 (
    .scan(scan), .well(well), .piece(piece), .piece_live(piece_live),
    .game_over(game_over), .board_color(board_color)
  );

  // Score lamps over the board, registered output
  score_overlay overlay0 (
    .hz100(hz100), .rst_n(rst_n), .scan(scan), .board_color(board_color),
    .score(score), .red(red), .green(green), .blue(blue),
    .hsync(hsync), .vsync(vsync)
  );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  // 8 ns period
  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

endmodule

`default_nettype wire

// File: verif/tetris_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tetris_tb import tetris_pkg::*; ();

  localparam int frame_cycles = h_total * v_total;
  localparam int stim_depth   = 64;

  // Button bits as indexed by the stim file with left as bit 0
  typedef struct packed {
    logic start;
    logic drop;
    logic rotate;
    logic right;
    logic left;
  } buttons_t;

  logic        clk;
  logic        rst_n;
  buttons_t    btn;
  logic        red;
  logic        green;
  logic        blue;
  logic        hsync;
  logic        vsync;
  logic        game_over;
  logic [7:0]  score;
  logic [31:0] stim [stim_depth];
  int          cyc;
  int          errors;
  int          checks;
  logic        stalled;

  tb_clock clk0 (.clk(clk));

  tetris_top dut0 (
    .hz100(clk), .rst_n(rst_n),
    .move_left(btn.left), .move_right(btn.right), .rotate(btn.rotate),
    .drop(btn.drop), .start(btn.start),
    .red(red), .green(green), .blue(blue), .hsync(hsync), .vsync(vsync),
    .game_over(game_over), .score(score)
  );

  // Cycles since reset release
  // Shares its origin with the DUT counters
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  task automatic report_stall(input string what);
    $display("Timeout while waiting for %s", what);
    errors++;
    stalled = 1'b1;
  endtask

  task automatic wait_vsync_fall();
    int n;
    n = 0;
    while (vsync !== 1'b1 && !stalled) begin
      @(negedge clk);
      n++;
      if (n > frame_cycles) report_stall("vsync to go high");
    end
    n = 0;
    while (vsync !== 1'b0 && !stalled) begin
      @(negedge clk);
      n++;
      if (n > 2 * frame_cycles) report_stall("a vsync falling edge");
    end
  endtask

  task automatic wait_hsync_fall();
    int n;
    n = 0;
    while (hsync !== 1'b1 && !stalled) begin
      @(negedge clk);
      n++;
      if (n > h_total) report_stall("hsync to go high");
    end
    n = 0;
    while (hsync !== 1'b0 && !stalled) begin
      @(negedge clk);
      n++;
      if (n > 2 * h_total) report_stall("an hsync falling edge");
    end
  endtask

  // Samples pixel (px,py) of the next frame
  // Line py is reached by the hsync edge of line py-1
  task automatic sample_pixel(input int px, input int py, output logic [2:0] rgb);
    rgb = 3'b000;
    wait_vsync_fall();
    for (int n = 0; n < py + v_total - v_sync_start; n++) begin
      wait_hsync_fall();
    end
    repeat (h_total - h_sync_start + px) @(negedge clk);
    rgb = {red, green, blue};
  endtask

  task automatic check_cell(input int col, input int row, input logic [2:0] exp);
    logic [2:0] got;
    // Center pixel of the cell
    sample_pixel(board_x0 + col * cell_px + cell_px / 2,
                 board_y0 + row * cell_px + cell_px / 2, got);
    if (stalled) return;
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] rgb at cell (%0d,%0d): got %h, expected %h", col, row, got, exp);
    end
  endtask

  task automatic check_lamps(input logic [7:0] exp);
    logic [2:0] got;
    logic [2:0] want;
    for (int i = 0; i < 8; i++) begin
      sample_pixel(board_x0 + i * cell_px + cell_px / 2, score_y0 + cell_px / 2, got);
      if (stalled) return;
      // Leftmost lamp is the MSB
      want = exp[7-i] ? 3'(color_yellow) : 3'(color_blue);
      checks++;
      assert (got === want) else begin
        errors++;
        $display("[FAIL] rgb at score lamp %0d: got %h, expected %h", 7 - i, got, want);
      end
    end
  endtask

  task automatic check_period();
    int t0;
    int t1;
    wait_vsync_fall();
    t0 = cyc;
    wait_vsync_fall();
    if (stalled) return;
    checks++;
    assert (cyc - t0 == frame_cycles) else begin
      errors++;
      $display("[FAIL] vsync period: got %h, expected %h", cyc - t0, frame_cycles);
    end
    // Line period between two hsync falling edges
    wait_hsync_fall();
    t1 = cyc;
    wait_hsync_fall();
    if (stalled) return;
    checks++;
    assert (cyc - t1 == h_total) else begin
      errors++;
      $display("[FAIL] hsync period: got %h, expected %h", cyc - t1, h_total);
    end
  endtask

  // Each press holds the button 4 cycles and releases it 4 cycles
  task automatic press(input int idx, input int count);
    for (int i = 0; i < count; i++) begin
      btn = buttons_t'(5'b00001 << idx);
      repeat (4) @(negedge clk);
      btn = '0;
      repeat (4) @(negedge clk);
    end
  endtask

  // Keeps presses away from gravity ticks
  task automatic align_phase(input int phase);
    int n;
    n = 0;
    while ((cyc % frame_cycles) != phase && !stalled) begin
      @(negedge clk);
      n++;
      if (n > 2 * frame_cycles) report_stall("the frame phase");
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    logic [31:0] word;
    int          op;
    int          col;
    int          row;
    int          val;
    btn     = '0;
    rst_n   = 1'b0;
    errors  = 0;
    checks  = 0;
    stalled = 1'b0;
    for (int i = 0; i < stim_depth; i++) begin
      stim[i] = '0;
    end
    $readmemh("verif/tetris_stim.txt", stim);
    // Four rising edges inside reset
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < stim_depth && !stalled; i++) begin
      word = stim[i];
      op   = int'(word[31:28]);
      col  = int'($signed(word[27:20]));
      row  = int'($signed(word[19:12]));
      val  = int'(word[11:0]);
      // Opcode 0 ends the script
      if (op == 0) break;
      case (op)
        1: press(col, val);
        2: repeat (val * tick_cycles) @(negedge clk);
        3: align_phase(val);
        4: check_cell(col, row, 3'(val));
        5: check_lamps(8'(val));
        6: begin
          checks++;
          assert (score === 8'(val)) else begin
            errors++;
            $display("[FAIL] score: got %h, expected %h", score, 8'(val));
          end
        end
        7: begin
          checks++;
          assert (game_over === val[0]) else begin
            errors++;
            $display("[FAIL] game_over: got %h, expected %h", game_over, val[0]);
          end
        end
        8: check_period();
        default: begin
          errors++;
          $display("Unknown opcode %0d in stim line %0d", op, i);
        end
      endcase
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: tetris_lite.f
logic/tetris_pkg.sv
logic/vga_timing.sv
logic/tick_divider.sv
logic/tetris_game.sv
logic/board_render.sv
logic/score_overlay.sv
logic/tetris_top.sv
verif/tb_clock.sv
verif/tetris_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tetris_lite.f --top-module tetris_tb \
  -Mdir obj_dir -o tetris_sim

out=$(./obj_dir/tetris_sim)
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
  exit 0
fi
exit 1

// File: verif/tetris_stim.txt
// op[31:28] col[27:20] row[19:12] value[11:0]; ops 1 press, 2 ticks, 3 align,
// 4 cell color, 5 lamps, 6 score, 7 game_over, 8 frame period, 0 end
80000000 // frame period
60000000 // score 0
70000000 // game_over 0
4FFFF007 // frame corner white
40000000 // empty well cell black
50000000 // lamps 00000000
30000064 // align phase 100
10400001 // start, O spawns at col 3
40303006 // O at row 3 after three ticks
40408006 // O at row 7 to 8
30000064
10000004 // left x4, last one blocked
4000D006 // O at col 0
40112006 // O rows 17 to 18
30000064
10300001 // drop locks O
300000C8 // align phase 200
10200001 // rotate I to vertical
10100006 // right x6, last one blocked
10200001 // rotate against wall refused
40903003 // vertical I at col 9, cyan
30000064
10000006 // left x6
10200001 // rotate back to flat
1030000E // drop 14, locks on row 19
30000190 // align phase 400
10200002 // T rotated twice
10100003 // right x3
10300013 // drop 19
300002BC // align phase 700
10200001 // L rotated once
10100005 // right x5
10300012 // drop 18, row 19 clears
60000001 // score 1
40013006 // O shifted down, yellow
40313000 // cleared cell black
40812007 // L cell white
50000001 // lamps 00000001
200001F4 // 500 ticks, stack reaches spawn
70000001 // game over
40013004 // stored cells red
40812004
10400001 // start back to idle
70000000
60000000
40013000 // well empty
50000000
00000000
